// ==== rob_pkg.sv ====
package rob_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // fixed sizes of the read channel
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // the channel talks to four cache banks
  localparam int unsigned NUM_BANKS = 4;

  // each bank can have this many answers in flight for one channel
  localparam int unsigned ROB_DEPTH = 8;

  // the keep-order FIFO holds 16 bank ids, one per outstanding request
  localparam int unsigned KOF_AW = 4;

  localparam int unsigned DATA_W = 128;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // types shared by the datapath
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  typedef logic [$clog2(NUM_BANKS)-1:0] bank_id_t;

  // reorder tag, echoed back by the bank with its answer
  typedef logic [$clog2(ROB_DEPTH)-1:0] rob_num_t;

  // up to four channels share the banks
  typedef logic [1:0] ch_id_t;

  typedef logic [DATA_W-1:0] data_t;

endpackage

// ==== bank_rtn_if.sv ====
`timescale 1ns/1ps

interface bank_rtn_if;
  import rob_pkg::*;

  // valid strobes for one cycle per answer, there is no ready
  logic     valid;
  ch_id_t   ch_id;
  rob_num_t rob_num;
  data_t    data;

  modport bank (
    output valid,
    output ch_id,
    output rob_num,
    output data
  );

  modport rob (
    input valid,
    input ch_id,
    input rob_num,
    input data
  );

endinterface

// ==== sync_fifo.sv ====
`timescale 1ns/1ps

module sync_fifo #(
  parameter int unsigned AW = 4,
  parameter int unsigned DW = 8
) (
  input  logic          clk_i,
  input  logic          rst_i,
  input  logic          push_i,
  input  logic [DW-1:0] din_i,
  input  logic          pop_i,
  output logic [DW-1:0] dout_o,
  output logic          empty_o,
  output logic          full_o
);

  localparam int unsigned DEPTH = 1 << AW;

  logic [DW-1:0] mem [DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [AW:0]   count;
  logic          do_push;
  logic          do_pop;

  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;

  assign empty_o = (count == '0);
  assign full_o  = (count == (AW+1)'(DEPTH));

  // the head is shown in the same cycle it is read
  assign dout_o = mem[rd_ptr];

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem[wr_ptr] <= din_i;
    end
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// ==== spw_buffer.sv ====
`timescale 1ns/1ps

module spw_buffer (
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic              wr_en_i,
  input  rob_pkg::rob_num_t wr_ptr_i,
  input  rob_pkg::data_t    wr_data_i,
  input  logic              rd_en_i,
  input  rob_pkg::rob_num_t rd_ptr_i,
  output logic              rd_valid_o,
  output rob_pkg::data_t    rd_data_o
);
  import rob_pkg::*;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // storage by tag
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // answers land at their own tag, in whatever order the bank sends them
  data_t                mem [ROB_DEPTH];
  logic [ROB_DEPTH-1:0] vld;

  always_ff @(posedge clk_i) begin
    if (wr_en_i) begin
      mem[wr_ptr_i] <= wr_data_i;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // valid bits
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // a tag is only reused after its credit came back, so a write and a
  // clear never hit the same entry in one cycle
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      vld <= '0;
    end else begin
      if (rd_en_i) begin
        vld[rd_ptr_i] <= 1'b0;
      end
      if (wr_en_i) begin
        vld[wr_ptr_i] <= 1'b1;
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // read side
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // the merge stage looks at one tag per bank and waits for it to fill
  assign rd_valid_o = vld[rd_ptr_i];
  assign rd_data_o  = mem[rd_ptr_i];

endmodule

// ==== rob_tag_alloc.sv ====
`timescale 1ns/1ps

module rob_tag_alloc (
  input  logic                          clk_i,
  input  logic                          rst_i,
  input  logic                          req_kickoff_i,
  input  rob_pkg::bank_id_t             req_bank_id_i,
  input  logic [rob_pkg::NUM_BANKS-1:0] bank_pop_i,
  output logic                          req_ready_o,
  output logic                          req_accept_o,
  output rob_pkg::rob_num_t             req_rob_num_o
);
  import rob_pkg::*;

  localparam int unsigned KOF_DEPTH = 1 << KOF_AW;
  localparam int unsigned BCW       = $clog2(ROB_DEPTH + 1);
  localparam int unsigned TCW       = $clog2(KOF_DEPTH + 1);

  rob_num_t       tag_arr [NUM_BANKS];
  logic [BCW-1:0] cnt_arr [NUM_BANKS];
  logic [TCW-1:0] total_cnt;
  logic           any_pop;

  // the merge stage pops at most one bank per cycle
  assign any_pop = |bank_pop_i;

  // stop when the bank has no free tag or the keep-order FIFO is full
  assign req_ready_o   = (cnt_arr[req_bank_id_i] != BCW'(ROB_DEPTH))
                      && (total_cnt != TCW'(KOF_DEPTH));
  assign req_accept_o  = req_kickoff_i && req_ready_o;
  assign req_rob_num_o = tag_arr[req_bank_id_i];

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      total_cnt <= '0;
    end else if (req_accept_o && !any_pop) begin
      total_cnt <= total_cnt + 1'b1;
    end else if (!req_accept_o && any_pop) begin
      total_cnt <= total_cnt - 1'b1;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // per-bank issue tag and credits
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
    rob_num_t       issue_tag;
    logic [BCW-1:0] outstanding;
    logic           acc_here;

    assign acc_here = req_accept_o && (req_bank_id_i == bank_id_t'(b));

    // issue tag wraps at 8, matching the read tag in the reorder block
    always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
        issue_tag   <= '0;
        outstanding <= '0;
      end else begin
        if (acc_here) begin
          issue_tag <= issue_tag + 1'b1;
        end
        if (acc_here && !bank_pop_i[b]) begin
          outstanding <= outstanding + 1'b1;
        end else if (!acc_here && bank_pop_i[b]) begin
          outstanding <= outstanding - 1'b1;
        end
      end
    end

    assign tag_arr[b] = issue_tag;
    assign cnt_arr[b] = outstanding;
  end

endmodule

// ==== cross_bar_rob.sv ====
`timescale 1ns/1ps

module cross_bar_rob #(
  parameter rob_pkg::ch_id_t CHANNEL_ID = '0
) (
  input  logic                          clk_i,
  input  logic                          rst_i,
  input  logic                          req_accept_i,
  input  rob_pkg::bank_id_t             req_bank_id_i,
  bank_rtn_if.rob                       bank_rtn [rob_pkg::NUM_BANKS],
  output logic                          ch_rtn_valid_o,
  input  logic                          ch_rtn_ready_i,
  output rob_pkg::data_t                ch_rtn_data_o,
  output logic [rob_pkg::NUM_BANKS-1:0] bank_pop_o
);
  import rob_pkg::*;

  bank_id_t             kof_head;
  logic                 kof_empty;
  logic                 rtn_fire;
  logic [NUM_BANKS-1:0] buf_rvalid;
  data_t                buf_rdata [NUM_BANKS];

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // keep-order FIFO
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // one entry per accepted request, holding only the target bank.
  // The allocator never lets it fill past 16, so full is not needed here
  sync_fifo #(
    .AW (KOF_AW),
    .DW ($bits(bank_id_t))
  ) u_keep_order_fifo (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .push_i  (req_accept_i),
    .din_i   (req_bank_id_i),
    .pop_i   (rtn_fire),
    .dout_o  (kof_head),
    .empty_o (kof_empty),
    .full_o  ()
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // per-bank sparse write buffers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
    rob_num_t rd_tag;
    logic     wr_en;
    logic     rd_en;

    // answers for other channels pass by without being stored
    assign wr_en = bank_rtn[b].valid && (bank_rtn[b].ch_id == CHANNEL_ID);

    // only the bank at the head of the order is ever read
    assign rd_en = rtn_fire && (kof_head == bank_id_t'(b));

    // next tag to hand out in order, steps on this bank's own read only
    always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
        rd_tag <= '0;
      end else if (rd_en) begin
        rd_tag <= rd_tag + 1'b1;
      end
    end

    spw_buffer u_spw_buffer (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .wr_en_i    (wr_en),
      .wr_ptr_i   (bank_rtn[b].rob_num),
      .wr_data_i  (bank_rtn[b].data),
      .rd_en_i    (rd_en),
      .rd_ptr_i   (rd_tag),
      .rd_valid_o (buf_rvalid[b]),
      .rd_data_o  (buf_rdata[b])
    );

    // the pop pulse returns the credit to the allocator and the bank
    assign bank_pop_o[b] = rd_en;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // return merge
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // valid follows only the head bank, so a later answer that arrives
  // early in another bank waits its turn
  assign ch_rtn_valid_o = !kof_empty && buf_rvalid[kof_head];
  assign ch_rtn_data_o  = buf_rdata[kof_head];

  // nothing moves while the consumer holds ready low, so valid and data hold
  assign rtn_fire = ch_rtn_valid_o && ch_rtn_ready_i;

endmodule

// ==== rob_channel_top.sv ====
`timescale 1ns/1ps

module rob_channel_top #(
  parameter rob_pkg::ch_id_t CHANNEL_ID = '0
) (
  input  logic                          clk_i,
  input  logic                          rst_i,

  // request side
  input  logic                          req_kickoff_i,
  input  rob_pkg::bank_id_t             req_bank_id_i,
  output logic                          req_ready_o,
  output rob_pkg::rob_num_t             req_rob_num_o,

  // bank answers
  input  logic [rob_pkg::NUM_BANKS-1:0] bank_valid_i,
  input  rob_pkg::ch_id_t               bank_ch_id_i   [rob_pkg::NUM_BANKS-1:0],
  input  rob_pkg::rob_num_t             bank_rob_num_i [rob_pkg::NUM_BANKS-1:0],
  input  rob_pkg::data_t                bank_data_i    [rob_pkg::NUM_BANKS-1:0],

  // in-order return
  output logic                          ch_rtn_valid_o,
  input  logic                          ch_rtn_ready_i,
  output rob_pkg::data_t                ch_rtn_data_o,
  output logic [rob_pkg::NUM_BANKS-1:0] bank_pop_o
);
  import rob_pkg::*;

  logic req_accept;

  bank_rtn_if bank_rtn [NUM_BANKS] ();

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // bank ports into the bundles
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // the top level stands in for the bank side of each bundle
  for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
    assign bank_rtn[b].valid   = bank_valid_i[b];
    assign bank_rtn[b].ch_id   = bank_ch_id_i[b];
    assign bank_rtn[b].rob_num = bank_rob_num_i[b];
    assign bank_rtn[b].data    = bank_data_i[b];
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // tag allocator
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  rob_tag_alloc u_tag_alloc (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .req_kickoff_i (req_kickoff_i),
    .req_bank_id_i (req_bank_id_i),
    .bank_pop_i    (bank_pop_o),
    .req_ready_o   (req_ready_o),
    .req_accept_o  (req_accept),
    .req_rob_num_o (req_rob_num_o)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // reorder block
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  cross_bar_rob #(
    .CHANNEL_ID (CHANNEL_ID)
  ) u_cross_bar_rob (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .req_accept_i   (req_accept),
    .req_bank_id_i  (req_bank_id_i),
    .bank_rtn       (bank_rtn),
    .ch_rtn_valid_o (ch_rtn_valid_o),
    .ch_rtn_ready_i (ch_rtn_ready_i),
    .ch_rtn_data_o  (ch_rtn_data_o),
    .bank_pop_o     (bank_pop_o)
  );

endmodule

// ==== tb_rob_channel.sv ====
`timescale 1ns/1ps

module tb_rob_channel;
  import rob_pkg::*;

  localparam ch_id_t CHANNEL_ID      = 2'd1;
  localparam int     TABLE_LEN       = 48;
  localparam int     WATCHDOG_CYCLES = TABLE_LEN * 64 + 200;

  // each entry is {stall, bank}; a stall entry holds the return ready low
  localparam logic [2:0] REQ_TABLE [TABLE_LEN] = '{
    3'd0, 3'd1, 3'd2, 3'd3, 3'd0, 3'd1, 3'd2, 3'd3, 3'd6, 3'd6, 3'd6, 3'd6,
    3'd6, 3'd6, 3'd6, 3'd6, 3'd6, 3'd6, 3'd6, 3'd6, 3'd3, 3'd1, 3'd0, 3'd2,
    3'd1, 3'd3, 3'd0, 3'd0, 3'd4, 3'd5, 3'd6, 3'd7, 3'd4, 3'd5, 3'd6, 3'd7,
    3'd4, 3'd5, 3'd6, 3'd7, 3'd4, 3'd5, 3'd6, 3'd7, 3'd4, 3'd5, 3'd1, 3'd3
  };

  logic           clk_i;
  logic           rst_i;
  logic           req_kickoff_i;
  bank_id_t       req_bank_id_i;
  logic           req_ready_o;
  rob_num_t       req_rob_num_o;
  logic [3:0]     bank_valid_i;
  ch_id_t         bank_ch_id_i   [NUM_BANKS-1:0];
  rob_num_t       bank_rob_num_i [NUM_BANKS-1:0];
  data_t          bank_data_i    [NUM_BANKS-1:0];
  logic           ch_rtn_valid_o;
  logic           ch_rtn_ready_i;
  data_t          ch_rtn_data_o;
  logic [3:0]     bank_pop_o;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // reference model state
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  int          out_cnt [NUM_BANKS];
  rob_num_t    issue_tag [NUM_BANKS];
  int          gap_cnt [NUM_BANKS];
  int unsigned pend_q [NUM_BANKS][$];
  // expected order holds serial, tag and bank of each accepted request
  int unsigned exp_q [$];
  int unsigned serial      = 0;
  int          total_out   = 0;
  int          done_cnt    = 0;
  int          foreign_cnt = 0;
  int          err_cnt     = 0;
  logic        hold_prev   = 1'b0;
  data_t       held_data;
  logic        saw_bank_full  = 1'b0;
  logic        saw_total_full = 1'b0;
  logic [31:0] lfsr_state     = 32'h0372_f76a;

  rob_channel_top #(
    .CHANNEL_ID (CHANNEL_ID)
  ) uut (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .req_kickoff_i  (req_kickoff_i),
    .req_bank_id_i  (req_bank_id_i),
    .req_ready_o    (req_ready_o),
    .req_rob_num_o  (req_rob_num_o),
    .bank_valid_i   (bank_valid_i),
    .bank_ch_id_i   (bank_ch_id_i),
    .bank_rob_num_i (bank_rob_num_i),
    .bank_data_i    (bank_data_i),
    .ch_rtn_valid_o (ch_rtn_valid_o),
    .ch_rtn_ready_i (ch_rtn_ready_i),
    .ch_rtn_data_o  (ch_rtn_data_o),
    .bank_pop_o     (bank_pop_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // helpers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // taps 32, 22, 2 and 1, one step per bit handed out
  function automatic logic [7:0] take_bits(int n);
    logic [7:0] bits;
    logic       fb;
    bits = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      bits = {bits[6:0], fb};
    end
    return bits;
  endfunction

  function automatic data_t make_data(bank_id_t bank, rob_num_t tag, int unsigned ser);
    return {ser, 32'(bank), 32'(tag), ~ser};
  endfunction

  task automatic abort_run();
    err_cnt++;
    $display("FAIL: see errors above");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_value(string name, logic [127:0] got, logic [127:0] exp);
    if (got !== exp) begin
      $display("FAIL at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
      abort_run();
    end
  endtask

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    $display("ERROR: the run did not finish in %0d cycles", WATCHDOG_CYCLES);
    abort_run();
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // bank models
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // each bank answers a random pending tag after a random gap, and
  // now and then sends an answer meant for another channel
  always @(posedge clk_i) begin
    int          idx;
    int unsigned ent;
    ch_id_t      other;
    if (!rst_i) begin
      for (int b = 0; b < NUM_BANKS; b++) begin
        bank_valid_i[b] <= 1'b0;
        if (gap_cnt[b] != 0 || pend_q[b].size() == 0) begin
          if (gap_cnt[b] != 0) begin
            gap_cnt[b] = gap_cnt[b] - 1;
          end
          if (take_bits(2) == 8'd0) begin
            other = ch_id_t'(take_bits(2));
            if (other == CHANNEL_ID) begin
              other = 2'd0;
            end
            bank_valid_i[b]   <= 1'b1;
            bank_ch_id_i[b]   <= other;
            bank_rob_num_i[b] <= rob_num_t'(take_bits(3));
            bank_data_i[b]    <= {120'h0bad, take_bits(8)};
            foreign_cnt = foreign_cnt + 1;
          end
        end else begin
          idx = int'(take_bits(3)) % pend_q[b].size();
          ent = pend_q[b][idx];
          pend_q[b].delete(idx);
          bank_valid_i[b]   <= 1'b1;
          bank_ch_id_i[b]   <= CHANNEL_ID;
          bank_rob_num_i[b] <= rob_num_t'(ent[2:0]);
          bank_data_i[b]    <= make_data(bank_id_t'(b), rob_num_t'(ent[2:0]), ent >> 3);
          gap_cnt[b] = int'(take_bits(3));
        end
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // output monitor
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always @(negedge clk_i) begin
    logic        exp_ready;
    int unsigned ent;
    bank_id_t    eb;
    if (!rst_i) begin
      exp_ready = (out_cnt[req_bank_id_i] < int'(ROB_DEPTH)) && (total_out < (1 << KOF_AW));
      check_value("req_ready_o", 128'(req_ready_o), 128'(exp_ready));
      if (out_cnt[req_bank_id_i] == int'(ROB_DEPTH)) begin
        saw_bank_full = 1'b1;
      end
      if (total_out == (1 << KOF_AW)) begin
        saw_total_full = 1'b1;
      end
      if (hold_prev) begin
        check_value("ch_rtn_valid_o", 128'(ch_rtn_valid_o), 128'd1);
        check_value("ch_rtn_data_o", ch_rtn_data_o, held_data);
      end
      if (ch_rtn_valid_o && ch_rtn_ready_i) begin
        if (exp_q.size() == 0) begin
          $display("ERROR: a return transfer came with no request outstanding");
          abort_run();
        end
        ent = exp_q.pop_front();
        eb  = bank_id_t'(ent[1:0]);
        check_value("ch_rtn_data_o", ch_rtn_data_o,
                    make_data(eb, rob_num_t'(ent[4:2]), ent >> 5));
        check_value("bank_pop_o", 128'(bank_pop_o), 128'(4'b0001 << eb));
        out_cnt[eb] = out_cnt[eb] - 1;
        total_out   = total_out - 1;
        done_cnt    = done_cnt + 1;
      end else begin
        check_value("bank_pop_o", 128'(bank_pop_o), 128'd0);
      end
      hold_prev = ch_rtn_valid_o && !ch_rtn_ready_i;
      held_data = ch_rtn_data_o;
      if (req_kickoff_i && req_ready_o) begin
        eb = req_bank_id_i;
        check_value("req_rob_num_o", 128'(req_rob_num_o), 128'(issue_tag[eb]));
        pend_q[eb].push_back((serial << 3) | 32'(issue_tag[eb]));
        exp_q.push_back((serial << 5) | (32'(issue_tag[eb]) << 2) | 32'(eb));
        issue_tag[eb] = issue_tag[eb] + 3'd1;
        serial        = serial + 1;
        out_cnt[eb]   = out_cnt[eb] + 1;
        total_out     = total_out + 1;
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // request sequence
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  initial begin
    int         issued;
    logic       stall_prev;
    logic [2:0] ent;
    issued         = 0;
    stall_prev     = 1'b0;
    rst_i          = 1'b1;
    req_kickoff_i  = 1'b0;
    req_bank_id_i  = '0;
    bank_valid_i   = '0;
    ch_rtn_ready_i = 1'b0;
    for (int b = 0; b < NUM_BANKS; b++) begin
      bank_ch_id_i[b]   = '0;
      bank_rob_num_i[b] = '0;
      bank_data_i[b]    = '0;
      out_cnt[b]        = 0;
      issue_tag[b]      = '0;
      gap_cnt[b]        = 0;
    end
    repeat (10) @(posedge clk_i);
    rst_i          <= 1'b0;
    ch_rtn_ready_i <= 1'b1;
    @(negedge clk_i);
    check_value("req_ready_o", 128'(req_ready_o), 128'd1);
    check_value("ch_rtn_valid_o", 128'(ch_rtn_valid_o), 128'd0);
    check_value("bank_pop_o", 128'(bank_pop_o), 128'd0);

    for (int i = 0; i < TABLE_LEN; i++) begin
      ent = REQ_TABLE[i];
      // a stall run starts from an empty reorder buffer so the credit limits are hit
      if (ent[2] && !stall_prev) begin
        wait (done_cnt == issued);
      end
      stall_prev = ent[2];
      @(posedge clk_i);
      req_bank_id_i  <= ent[1:0];
      ch_rtn_ready_i <= !ent[2];
      @(negedge clk_i);
      // out of credits, so let the output drain until a pop frees one
      while (!req_ready_o) begin
        @(posedge clk_i);
        ch_rtn_ready_i <= 1'b1;
        @(negedge clk_i);
      end
      @(posedge clk_i);
      req_kickoff_i <= 1'b1;
      @(negedge clk_i);
      issued = issued + 1;
      @(posedge clk_i);
      req_kickoff_i <= 1'b0;
    end
    ch_rtn_ready_i <= 1'b1;
    wait (done_cnt == TABLE_LEN);
    @(negedge clk_i);

    if (!saw_bank_full) begin
      $display("ERROR: req_ready_o never dropped with eight answers outstanding on a bank");
      abort_run();
    end
    if (!saw_total_full) begin
      $display("ERROR: req_ready_o never dropped with sixteen requests outstanding");
      abort_run();
    end
    if (foreign_cnt == 0) begin
      $display("ERROR: no answer for another channel was injected");
      abort_run();
    end
    if (err_cnt == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// ==== verilog.f ====
rob_pkg.sv
bank_rtn_if.sv
sync_fifo.sv
spw_buffer.sv
rob_tag_alloc.sv
cross_bar_rob.sv
rob_channel_top.sv
tb_rob_channel.sv

// ==== Makefile ====
TOP = tb_rob_channel

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f verilog.f --top-module rob_channel_top
	verilator --lint-only --timing -f verilog.f --top-module $(TOP)

sim:
	verilator --binary --timing -j 0 -f verilog.f --top-module $(TOP)
	@out=$$(./obj_dir/V$(TOP) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -qx "PASS: all tests"

clean:
	rm -rf obj_dir
